// File: project.f
rtl/coreTypes.sv
rtl/pipeBus.sv
rtl/aluUnit.sv
rtl/fetchUnit.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/resultStage.sv
rtl/miniCore.sv
bench/miniCoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the miniCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module miniCoreTb -Mdir obj_dir -f project.f > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/VminiCoreTb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if grep -q "^TESTBENCH PASSED$" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: bench/miniCoreTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for miniCore. Wishbone program memory with random wait states,
// an ISA reference model that fills the expected retire list, and
// concurrent assertions on retire, halt and bus behavior
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module miniCoreTb;
   import coreTypes::*;

   localparam int          clkPeriod = 40;
   localparam logic [15:0] resetPc   = 16'h0008;   // Program starts past address 0

   logic        clk;
   logic        reset;
   logic [15:0] wbDatIn;
   logic        wbAck;
   logic        wbCyc, wbStb;
   logic [15:0] wbAdr;
   logic        retireValid;
   logic [2:0]  retireReg;
   logic [15:0] retireData;
   logic        halted;

   logic [15:0] progMem [256];
   logic [2:0]  expReg  [256];     // Expected retire list from the model
   logic [15:0] expData [256];
   int          expCount;
   int          headIdx;           // Next expected retire
   int          stepCount;         // Instructions run by the model
   int          errors;
   int          waitLeft;
   int          seed;
   bit          refReady;

   miniCore #(.resetPc(resetPc)) dut (
      .clk         (clk),
      .reset       (reset),
      .wbDatIn     (wbDatIn),
      .wbAck       (wbAck),
      .wbCyc       (wbCyc),
      .wbStb       (wbStb),
      .wbAdr       (wbAdr),
      .retireValid (retireValid),
      .retireReg   (retireReg),
      .retireData  (retireData),
      .halted      (halted)
   );

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   // Instruction encoders
   function automatic logic [15:0] regInst(input logic [4:0] op, input int rd, rs, rt);
      regInst = {op, rs[2:0], rt[2:0], rd[2:0], 2'b00};
   endfunction

   function automatic logic [15:0] addiInst(input int rd, rs, imm);
      addiInst = {OP_ADDI, rs[2:0], rd[2:0], imm[4:0]};
   endfunction

   function automatic logic [15:0] branchInst(input logic [4:0] op, input int rs, off);
      branchInst = {op, rs[2:0], off[7:0]};
   endfunction

   function automatic logic [15:0] jumpInst(input int off);
      jumpInst = {OP_J, off[10:0]};
   endfunction

   task automatic loadProgram();
      logic [15:0] prog [35];
      prog[0]  = addiInst(1, 0, 5);                 // r1 = 5
      prog[1]  = addiInst(2, 1, -3);                // Negative imm, forwarded r1
      prog[2]  = regInst(OP_ADD, 3, 1, 2);          // Two back via write-through
      prog[3]  = regInst(OP_SUB, 4, 3, 1);
      prog[4]  = regInst(OP_AND, 5, 4, 3);
      prog[5]  = regInst(OP_OR, 6, 5, 1);
      prog[6]  = regInst(OP_XOR, 7, 6, 2);
      prog[7]  = regInst(OP_ADD, 1, 7, 5);
      prog[8]  = {OP_NOP, 11'h000};
      prog[9]  = {5'b10101, 11'h2aa};               // Unused code, acts as NOP
      prog[10] = regInst(OP_SUB, 2, 0, 1);          // r2 = -7
      prog[11] = branchInst(OP_BEQZ, 4, 2);         // Not taken
      prog[12] = branchInst(OP_BNEZ, 4, 1);         // Taken
      prog[13] = addiInst(3, 3, 1);                 // Flushed
      prog[14] = branchInst(OP_BLTZ, 2, 1);         // Taken
      prog[15] = addiInst(3, 3, 2);
      prog[16] = branchInst(OP_BGEZ, 2, 3);         // Not taken
      prog[17] = branchInst(OP_BLTZ, 1, 3);         // Not taken
      prog[18] = branchInst(OP_BGEZ, 1, 1);         // Taken
      prog[19] = addiInst(3, 3, 3);
      prog[20] = regInst(OP_SUB, 5, 5, 5);          // r5 = 0
      prog[21] = branchInst(OP_BEQZ, 5, 1);         // Taken on forwarded zero
      prog[22] = addiInst(3, 3, 4);
      prog[23] = branchInst(OP_BNEZ, 5, 2);         // Not taken
      prog[24] = jumpInst(2);
      prog[25] = addiInst(6, 6, 1);                 // Skipped by J
      prog[26] = addiInst(6, 6, 2);
      prog[27] = addiInst(6, 6, -16);
      prog[28] = addiInst(4, 0, 3);                 // Loop count
      prog[29] = addiInst(4, 4, -1);
      prog[30] = branchInst(OP_BNEZ, 4, -2);        // Backward, taken twice
      prog[31] = regInst(OP_XOR, 7, 7, 6);
      prog[32] = {OP_HALT, 11'h000};
      prog[33] = addiInst(1, 1, 1);                 // Past HALT, never retires
      prog[34] = addiInst(2, 2, 1);
      for (int a = 0; a < 256; a++)
         progMem[a] = {OP_NOP, 3'b000, a[7:0]};     // NOP with its own address
      for (int i = 0; i < 35; i++)
         progMem[resetPc[7:0] + i] = prog[i];
   endtask

   task automatic pushExpect(input logic [2:0] r, input logic [15:0] d);
      expReg[expCount]  = r;
      expData[expCount] = d;
      expCount++;
   endtask

   // ISA reference run over the same memory image
   task automatic runReference();
      logic [15:0] regs [8];
      logic [15:0] pc, word, a, b, val, off;
      logic [4:0]  op;
      bit          done;
      bit          taken;
      for (int i = 0; i < 8; i++)
         regs[i] = '0;
      pc = resetPc;
      done = 1'b0;
      expCount = 0;
      stepCount = 0;
      while (!done && stepCount < 500) begin
         word = progMem[pc[7:0]];
         op   = word[15:11];
         a    = regs[word[10:8]];
         b    = regs[word[7:5]];
         pc   = pc + 16'd1;
         stepCount++;
         case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
               case (op)
                  OP_ADD:  val = a + b;
                  OP_SUB:  val = a - b;
                  OP_AND:  val = a & b;
                  OP_OR:   val = a | b;
                  default: val = a ^ b;
               endcase
               if (word[4:2] != 3'd0)
                  regs[word[4:2]] = val;
               pushExpect(word[4:2], val);
            end
            OP_ADDI: begin
               val = a + {{11{word[4]}}, word[4:0]};
               if (word[7:5] != 3'd0)
                  regs[word[7:5]] = val;
               pushExpect(word[7:5], val);
            end
            OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
               off = {{8{word[7]}}, word[7:0]};
               case (op)
                  OP_BEQZ: taken = (a == 16'd0);
                  OP_BNEZ: taken = (a != 16'd0);
                  OP_BLTZ: taken = a[15];
                  default: taken = !a[15];
               endcase
               if (taken)
                  pc = pc + off;
               pushExpect(3'd0, 16'd0);
            end
            OP_J: begin
               pc = pc + {{5{word[10]}}, word[10:0]};
               pushExpect(3'd0, 16'd0);
            end
            OP_HALT: begin
               pushExpect(3'd0, 16'd0);
               done = 1'b1;
            end
            default: ;                              // NOP and unused codes
         endcase
      end
      if (!done) begin
         $display("Reference model did not reach HALT within %0d steps", stepCount);
         errors++;
      end
   endtask

   // Wishbone program memory, 0 to 3 wait states per access
   always @(posedge clk) begin
      if (reset) begin
         wbAck    <= 1'b0;
         waitLeft <= 0;
      end else if (wbAck) begin
         wbAck <= 1'b0;
      end else if (wbCyc && wbStb) begin
         if (waitLeft == 0) begin
            wbAck    <= 1'b1;
            wbDatIn  <= progMem[wbAdr[7:0]];
            waitLeft <= {$random(seed)} % 4;
         end else begin
            waitLeft <= waitLeft - 1;
         end
      end
   end

   always @(posedge clk) begin
      if (!reset && retireValid)
         headIdx <= headIdx + 1;                    // Pop the expected entry
   end

   retireInOrder: assert property (@(posedge clk) disable iff (reset)
      retireValid |-> headIdx < expCount)
      else begin
         errors++;
         $display("Unexpected retire at %0t after the last expected instruction", $time);
      end

   retireRegOk: assert property (@(posedge clk) disable iff (reset)
      (retireValid && headIdx < expCount) |-> retireReg == expReg[headIdx])
      else begin
         errors++;
         $display("Error at %0t: retireReg expected %0d got %0d",
                  $time, expReg[headIdx], retireReg);
      end

   retireDataOk: assert property (@(posedge clk) disable iff (reset)
      (retireValid && headIdx < expCount) |-> retireData == expData[headIdx])
      else begin
         errors++;
         $display("Error at %0t: retireData expected %h got %h",
                  $time, expData[headIdx], retireData);
      end

   haltFollowsRetire: assert property (@(posedge clk) disable iff (reset)
      (retireValid && headIdx == expCount - 1) |=> halted)
      else begin
         errors++;
         $display("Error at %0t: halted expected 1 got %b", $time, halted);
      end

   quietWhenHalted: assert property (@(posedge clk) disable iff (reset)
      halted |-> (!retireValid && headIdx == expCount))
      else begin
         errors++;
         $display("Retire activity or expected entries left at %0t after halt", $time);
      end

   stbWithCyc: assert property (@(posedge clk) disable iff (reset)
      wbStb |-> wbCyc)
      else begin
         errors++;
         $display("Strobe high without cycle at %0t", $time);
      end

   busHeld: assert property (@(posedge clk) disable iff (reset)
      (wbCyc && !wbAck) |=> (wbCyc && wbStb && $stable(wbAdr)))
      else begin
         errors++;
         $display("Bus cycle dropped or address changed before ack at %0t", $time);
      end

   noFetchHalted: assert property (@(posedge clk) disable iff (reset)
      (halted && !wbCyc) |=> !wbCyc)
      else begin
         errors++;
         $display("New fetch started at %0t while halted", $time);
      end

   adrInMemory: assert property (@(posedge clk) disable iff (reset)
      wbCyc |-> wbAdr[15:8] == 8'd0)
      else begin
         errors++;
         $display("Fetch address %h outside program memory at %0t", wbAdr, $time);
      end

   initial begin : watchdog
      int limitCycles;
      wait (refReady);
      limitCycles = stepCount * 4 * 8 + 100;       // Worst fetch per step plus margin
      repeat (limitCycles) @(posedge clk);
      errors++;
      $display("Timeout: core did not halt within %0d cycles", limitCycles);
      $display("Summary: %0d of %0d retires seen, %0d errors", headIdx, expCount, errors);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      reset    = 1'b1;
      wbAck    = 1'b0;
      wbDatIn  = '0;
      seed     = 49912;
      errors   = 0;
      headIdx  = 0;
      refReady = 1'b0;
      loadProgram();
      runReference();
      refReady = 1'b1;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
      wait (halted);
      repeat (10) @(posedge clk);                   // Anything behind HALT would show
      if (headIdx != expCount) begin
         errors++;
         $display("Only %0d of %0d expected retires seen", headIdx, expCount);
      end
      $display("Summary: %0d of %0d retires seen, %0d errors", headIdx, expCount, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: rtl/miniCore.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the three-stage core. Wishbone read master for instructions
// and a retire report port; resetPc sets the first fetch address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module miniCore #(
   parameter logic [coreTypes::dataWidth-1:0] resetPc = '0
) (
   input  logic                               clk,
   input  logic                               reset,
   input  logic [coreTypes::dataWidth-1:0]    wbDatIn,
   input  logic                               wbAck,
   output logic                               wbCyc,
   output logic                               wbStb,
   output logic [coreTypes::dataWidth-1:0]    wbAdr,
   output logic                               retireValid,
   output logic [coreTypes::regAddrWidth-1:0] retireReg,
   output logic [coreTypes::dataWidth-1:0]    retireData,
   output logic                               halted
);
   import coreTypes::*;

   logic                 instValid;
   logic [dataWidth-1:0] instWord, instPc;
   logic                 redirect, haltSeen;
   logic [dataWidth-1:0] redirectPc;
   logic                 flush;         // Kill younger work, stop fetching

   assign flush = redirect || haltSeen;

   decExBus decEx ();
   exResBus exRes ();

   fetchUnit #(.resetPc(resetPc)) fetch (
      .clk        (clk),
      .reset      (reset),
      .wbDatIn    (wbDatIn),
      .wbAck      (wbAck),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .stop       (flush),
      .wbCyc      (wbCyc),
      .wbStb      (wbStb),
      .wbAdr      (wbAdr),
      .instValid  (instValid),
      .instWord   (instWord),
      .instPc     (instPc)
   );

   decodeStage decode (
      .clk       (clk),
      .reset     (reset),
      .instValid (instValid),
      .instWord  (instWord),
      .instPc    (instPc),
      .flush     (flush),
      .decEx     (decEx.dec),
      .wb        (exRes.wb)
   );

   executeStage execute (
      .clk        (clk),
      .reset      (reset),
      .decEx      (decEx.ex),
      .exRes      (exRes.ex),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .haltSeen   (haltSeen)
   );

   resultStage result (
      .clk         (clk),
      .reset       (reset),
      .exRes       (exRes.res),
      .retireValid (retireValid),
      .retireReg   (retireReg),
      .retireData  (retireData),
      .halted      (halted)
   );

endmodule

`default_nettype wire

// File: rtl/resultStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result stage. Drives the register file write port, reports each retired
// instruction and holds the sticky halted flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module resultStage (
   input  logic                               clk,
   input  logic                               reset,
   exResBus.res                               exRes,
   output logic                               retireValid,
   output logic [coreTypes::regAddrWidth-1:0] retireReg,
   output logic [coreTypes::dataWidth-1:0]    retireData,
   output logic                               halted
);

   // File writes at the end of this cycle
   assign exRes.wrEn   = exRes.valid && exRes.regWrite && (exRes.rdIdx != '0);
   assign exRes.wrIdx  = exRes.rdIdx;
   assign exRes.wrData = exRes.result;

   assign retireValid = exRes.valid;   // NOPs already dropped in execute
   assign retireReg   = exRes.rdIdx;
   assign retireData  = exRes.result;

   always_ff @(posedge clk) begin
      if (reset)
         halted <= 1'b0;
      else if (exRes.valid && exRes.isHalt)
         halted <= 1'b1;               // Stays until reset
   end

   // Flush and fetch stop must leave nothing behind the HALT
   quietAfterHalt: assert property (@(posedge clk) disable iff (reset)
      halted |-> !retireValid);

endmodule

`default_nettype wire

// File: rtl/executeStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute stage with forwarding from EX/RES, the ALU, branch and jump
// resolution and the EX/RES register. Redirect is combinational this cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module executeStage (
   input  logic                            clk,
   input  logic                            reset,
   decExBus.ex                             decEx,
   exResBus.ex                             exRes,
   output logic                            redirect,
   output logic [coreTypes::dataWidth-1:0] redirectPc,
   output logic                            haltSeen
);
   import coreTypes::*;

   logic                 fwdLive;             // EX/RES holds a real write
   logic [dataWidth-1:0] opA, opB, aluB, aluOut;
   logic                 branchTaken;

   // Only one stage to forward from, older results are already in the file
   assign fwdLive = exRes.valid && exRes.regWrite && (exRes.rdIdx != '0);
   assign opA  = (fwdLive && exRes.rdIdx == decEx.rsIdx) ? exRes.result : decEx.rsData;
   assign opB  = (fwdLive && exRes.rdIdx == decEx.rtIdx) ? exRes.result : decEx.rtData;
   assign aluB = decEx.useImm ? decEx.imm : opB;

   aluUnit alu (
      .inA (opA),
      .inB (aluB),
      .op  (decEx.aluOp),
      .out (aluOut)
   );

   always_comb begin
      case (decEx.op)
         OP_BEQZ: branchTaken = (aluOut == '0);
         OP_BNEZ: branchTaken = (aluOut != '0);
         OP_BLTZ: branchTaken = aluOut[dataWidth-1];    // Negative
         OP_BGEZ: branchTaken = !aluOut[dataWidth-1];
         default: branchTaken = 1'b0;
      endcase
   end

   assign redirect   = decEx.valid && (branchTaken || decEx.op == OP_J);
   assign redirectPc = decEx.nextPc + decEx.imm;        // Same adder for J
   assign haltSeen   = decEx.valid && (decEx.op == OP_HALT);

   always_ff @(posedge clk) begin
      if (reset)
         exRes.valid <= 1'b0;
      else
         exRes.valid <= decEx.valid && (decEx.op != OP_NOP);   // NOPs vanish here
   end

   always_ff @(posedge clk) begin
      exRes.rdIdx    <= decEx.rdIdx;
      exRes.regWrite <= decEx.regWrite;
      exRes.result   <= decEx.regWrite ? aluOut : '0;  // Zero for branch, J, HALT
      exRes.isHalt   <= (decEx.op == OP_HALT);
   end

   // A redirect always kills the word decode holds this cycle
   redirectFlush: assert property (@(posedge clk) disable iff (reset)
      redirect |=> !decEx.valid);

endmodule

`default_nettype wire

// File: rtl/decodeStage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage with the 8-entry register file. Decodes one word per
// instValid pulse into the ID/EX register; flush kills the word in decode
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            instValid,
   input  logic [coreTypes::dataWidth-1:0] instWord,
   input  logic [coreTypes::dataWidth-1:0] instPc,
   input  logic                            flush,
   decExBus.dec                            decEx,
   exResBus.wb                             wb
);
   import coreTypes::*;

   logic [dataWidth-1:0]    regFile [1 << regAddrWidth];
   logic [opWidth-1:0]      rawOp;
   opcodeT                  op;
   aluOpT                   aluOp;
   logic                    regWrite, useImm;
   logic [regAddrWidth-1:0] rsIdx, rtIdx, rdIdx;
   logic [dataWidth-1:0]    rsData, rtData, imm, nextPc;

   assign rawOp  = instWord[opMsb -: opWidth];
   assign rsIdx  = instWord[rsMsb -: regAddrWidth];
   assign rtIdx  = instWord[rtMsb -: regAddrWidth];
   assign nextPc = instPc + 1'b1;

   // r0 reads zero, a same-cycle write is seen at once
   assign rsData = (rsIdx == '0) ? '0 :
                   (wb.wrEn && wb.wrIdx == rsIdx) ? wb.wrData : regFile[rsIdx];
   assign rtData = (rtIdx == '0) ? '0 :
                   (wb.wrEn && wb.wrIdx == rtIdx) ? wb.wrData : regFile[rtIdx];

   always_comb begin
      case (rawOp)
         OP_HALT, OP_J, OP_ADDI, OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ,
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: op = opcodeT'(rawOp);
         default: op = OP_NOP;                 // Unused codes
      endcase
   end

   always_comb begin
      regWrite = 1'b0;
      useImm   = 1'b0;
      rdIdx    = '0;                           // Non-writers retire as r0
      imm      = '0;
      case (op)
         OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
            regWrite = 1'b1;
            rdIdx    = instWord[rdRegMsb -: regAddrWidth];
         end
         OP_ADDI: begin
            regWrite = 1'b1;
            useImm   = 1'b1;
            rdIdx    = instWord[rdImmMsb -: regAddrWidth];
            imm = {{(dataWidth-immIWidth){instWord[immIWidth-1]}}, instWord[immIWidth-1:0]};
         end
         OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ:
            imm = {{(dataWidth-brOffWidth){instWord[brOffWidth-1]}},
                   instWord[brOffWidth-1:0]};
         OP_J:
            imm = {{(dataWidth-jOffWidth){instWord[jOffWidth-1]}}, instWord[jOffWidth-1:0]};
         default: ;
      endcase
   end

   always_comb begin
      case (op)
         OP_ADD, OP_ADDI: aluOp = ALU_ADD;
         OP_SUB:          aluOp = ALU_SUB;
         OP_AND:          aluOp = ALU_AND;
         OP_OR:           aluOp = ALU_OR;
         OP_XOR:          aluOp = ALU_XOR;
         default:         aluOp = ALU_PASSA;   // Branches test rs as is
      endcase
   end

   always_ff @(posedge clk) begin
      if (wb.wrEn)
         regFile[wb.wrIdx] <= wb.wrData;
   end

   always_ff @(posedge clk) begin
      if (reset)
         decEx.valid <= 1'b0;
      else
         decEx.valid <= instValid && !flush;   // Younger than a redirect or HALT
   end

   always_ff @(posedge clk) begin
      decEx.op       <= op;
      decEx.aluOp    <= aluOp;
      decEx.rsIdx    <= rsIdx;
      decEx.rtIdx    <= rtIdx;
      decEx.rsData   <= rsData;
      decEx.rtData   <= rtData;
      decEx.rdIdx    <= rdIdx;
      decEx.regWrite <= regWrite;
      decEx.useImm   <= useImm;
      decEx.imm      <= imm;
      decEx.nextPc   <= nextPc;
   end

endmodule

`default_nettype wire

// File: rtl/fetchUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction fetch as a Wishbone classic read master. One word buffered,
// handed to decode as a one-cycle instValid pulse. Redirect drops stale words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module fetchUnit #(
   parameter logic [coreTypes::dataWidth-1:0] resetPc = '0
) (
   input  logic                             clk,
   input  logic                             reset,
   input  logic [coreTypes::dataWidth-1:0]  wbDatIn,
   input  logic                             wbAck,
   input  logic                             redirect,
   input  logic [coreTypes::dataWidth-1:0]  redirectPc,
   input  logic                             stop,       // Redirect or HALT in execute
   output logic                             wbCyc,
   output logic                             wbStb,
   output logic [coreTypes::dataWidth-1:0]  wbAdr,
   output logic                             instValid,
   output logic [coreTypes::dataWidth-1:0]  instWord,
   output logic [coreTypes::dataWidth-1:0]  instPc
);
   import coreTypes::*;

   typedef enum logic [1:0] {FETCH_IDLE, FETCH_REQ, FETCH_DISCARD} fetchStateT;

   fetchStateT           state;
   logic [dataWidth-1:0] pc;
   logic [dataWidth-1:0] reqAdr;    // Held for the whole bus cycle
   logic                 stopped;   // Sticky after HALT

   assign wbCyc = (state != FETCH_IDLE);
   assign wbStb = wbCyc;             // Classic, no pipelining
   assign wbAdr = reqAdr;

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= FETCH_IDLE;
         pc        <= resetPc;
         stopped   <= 1'b0;
         instValid <= 1'b0;
      end else begin
         instValid <= 1'b0;                    // One-cycle pulse, decode never stalls
         if (stop && !redirect)
            stopped <= 1'b1;                   // Only HALT stops without redirect
         if (redirect)
            pc <= redirectPc;
         case (state)
            FETCH_IDLE: begin
               if (!stop && !stopped)
                  state <= FETCH_REQ;
            end
            FETCH_REQ: begin
               if (wbAck) begin
                  state <= FETCH_IDLE;
                  if (!stop) begin             // Word still on the right path
                     instValid <= 1'b1;
                     pc        <= pc + 1'b1;
                  end
               end else if (stop) begin
                  state <= FETCH_DISCARD;      // Let the cycle finish, drop the word
               end
            end
            FETCH_DISCARD: begin
               if (wbAck)
                  state <= FETCH_IDLE;
            end
            default: state <= FETCH_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == FETCH_IDLE)
         reqAdr <= pc;                         // Latched as the cycle starts
      if (state == FETCH_REQ && wbAck) begin
         instWord <= wbDatIn;
         instPc   <= reqAdr;
      end
   end

   // Address and strobe hold until the slave acks
   adrStable: assert property (@(posedge clk) disable iff (reset)
      (wbStb && !wbAck) |=> (wbStb && $stable(wbAdr)));

endmodule

`default_nettype wire

// File: rtl/aluUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational 16-bit ALU used by the execute stage. Pass-A feeds the
// branch zero and sign tests
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
   input  logic [coreTypes::dataWidth-1:0] inA,
   input  logic [coreTypes::dataWidth-1:0] inB,
   input  coreTypes::aluOpT                op,
   output logic [coreTypes::dataWidth-1:0] out
);
   import coreTypes::*;

   always_comb begin
      case (op)
         ALU_ADD:   out = inA + inB;    // Wraps, no overflow flag
         ALU_SUB:   out = inA - inB;
         ALU_AND:   out = inA & inB;
         ALU_OR:    out = inA | inB;
         ALU_XOR:   out = inA ^ inB;
         ALU_PASSA: out = inA;
         default:   out = '0;
      endcase
   end

endmodule

`default_nettype wire

// File: rtl/pipeBus.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Pipeline register bundles between stages. decExBus carries ID/EX,
// exResBus carries EX/RES plus the write-back port into the register file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

interface decExBus;
   import coreTypes::*;

   logic                    valid;
   opcodeT                  op;
   aluOpT                   aluOp;
   logic [regAddrWidth-1:0] rsIdx, rtIdx;    // Kept for forwarding compares
   logic [dataWidth-1:0]    rsData, rtData;
   logic [regAddrWidth-1:0] rdIdx;
   logic                    regWrite;
   logic                    useImm;          // ALU B from imm instead of rt
   logic [dataWidth-1:0]    imm;             // Already sign extended
   logic [dataWidth-1:0]    nextPc;          // Branch base

   modport dec (output valid, op, aluOp, rsIdx, rtIdx, rsData, rtData,
                rdIdx, regWrite, useImm, imm, nextPc);
   modport ex  (input  valid, op, aluOp, rsIdx, rtIdx, rsData, rtData,
                rdIdx, regWrite, useImm, imm, nextPc);
endinterface

interface exResBus;
   import coreTypes::*;

   logic                    valid;           // Never set for NOP
   logic [regAddrWidth-1:0] rdIdx;
   logic                    regWrite;
   logic [dataWidth-1:0]    result;
   logic                    isHalt;
   logic                    wrEn;            // Write-back, driven by result stage
   logic [regAddrWidth-1:0] wrIdx;
   logic [dataWidth-1:0]    wrData;

   modport ex  (output valid, rdIdx, regWrite, result, isHalt);
   modport res (input valid, rdIdx, regWrite, result, isHalt,
                output wrEn, wrIdx, wrData);
   modport wb  (input wrEn, wrIdx, wrData);
endinterface

`default_nettype wire

// File: rtl/coreTypes.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, opcode and ALU encodings and instruction field positions
// for the three-stage core. Imported by every stage and by both pipe buses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package coreTypes;

   localparam int dataWidth    = 16;   // Data and instruction word
   localparam int regAddrWidth = 3;    // 8 registers, r0 hardwired zero

   // Field positions, given as msb plus width
   localparam int opMsb      = 15;
   localparam int opWidth    = 5;
   localparam int rsMsb      = 10;     // Source for R, ADDI and branch
   localparam int rtMsb      = 7;      // Second source, R-format only
   localparam int rdRegMsb   = 4;      // R-format destination
   localparam int rdImmMsb   = 7;      // ADDI destination
   localparam int immIWidth  = 5;      // ADDI immediate, bits 4..0
   localparam int brOffWidth = 8;      // Branch offset, bits 7..0
   localparam int jOffWidth  = 11;     // Jump offset, bits 10..0

   // Unlisted codes decode as NOP
   typedef enum logic [opWidth-1:0] {
      OP_HALT = 5'b00000,
      OP_NOP  = 5'b00001,
      OP_J    = 5'b00100,
      OP_ADDI = 5'b01000,
      OP_BEQZ = 5'b01100,
      OP_BNEZ = 5'b01101,
      OP_BLTZ = 5'b01110,
      OP_BGEZ = 5'b01111,
      OP_ADD  = 5'b11000,
      OP_SUB  = 5'b11001,   // rd = rs - rt
      OP_AND  = 5'b11010,
      OP_OR   = 5'b11011,
      OP_XOR  = 5'b11100
   } opcodeT;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASSA     // Branch test value and don't-care ops
   } aluOpT;

endpackage

`default_nettype wire
